// ==== files.f ====
rtl/ni_noc_pkg.sv
rtl/ni_regs_pkg.sv
rtl/ni_reg_slave.sv
rtl/ni_send_dma.sv
rtl/ni_flit_framer.sv
rtl/ni_master.sv
sim/ni_master_chk.sv
sim/ni_master_tb.sv

// ==== Makefile ====
# Verilator build and run for the DMA network interface master

TOP := ni_master_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f files.f

run: build
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "Simulation completed successfully" sim.log

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f files.f

clean:
	rm -rf obj_dir sim.log

// ==== sim/ni_master_tb.sv ====
// testbench for the DMA network interface master
// memory model with random ack delay, link sink with credit return
// directed tests, typed compare tasks, cycle timeout

`timescale 1ns/100ps
`default_nettype none

module ni_master_tb;
    import ni_noc_pkg::*;
    import ni_regs_pkg::*;

    localparam int       B         = 4;
    localparam e_addr_t  OWN_ADDR  = 8'h17;
    localparam payload_t MEM_XOR   = 32'h5a5a_0000;   // memory data = address ^ this
    localparam int       RAND_PCKS = 6;
    // words per test times 20, plus margin
    localparam int TIMEOUT_CYCLES = (5 + 9 + 6 + 4 + 4 + RAND_PCKS * 16) * 20 + 2000;

    logic      clk;
    logic      reset;
    e_addr_t   current_e_addr_i;
    reg_addr_t s_addr_i;
    payload_t  s_dat_i;
    logic      s_stb_i;
    logic      s_we_i;
    payload_t  s_dat_o;
    logic      s_ack_o;
    mem_addr_t m_addr_o;
    logic      m_stb_o;
    payload_t  m_dat_i;
    logic      m_ack_i;
    flit_t     flit_o;
    logic      flit_wr_o;
    logic      credit_i;
    logic      irq_o;

    flit_t rx_q[$];        // flits seen on the link
    int    owed_credits;
    int    cred_wait;
    int    mem_wait;
    logic  hold_credits;
    int    check_cnt;
    int    err_cnt;
    int    cycle_cnt;

    ni_master #(
        .B (B)
    ) u_ni_master (
        .clk              (clk),
        .reset            (reset),
        .current_e_addr_i (current_e_addr_i),
        .s_addr_i         (s_addr_i),
        .s_dat_i          (s_dat_i),
        .s_stb_i          (s_stb_i),
        .s_we_i           (s_we_i),
        .s_dat_o          (s_dat_o),
        .s_ack_o          (s_ack_o),
        .m_addr_o         (m_addr_o),
        .m_stb_o          (m_stb_o),
        .m_dat_i          (m_dat_i),
        .m_ack_i          (m_ack_i),
        .flit_o           (flit_o),
        .flit_wr_o        (flit_wr_o),
        .credit_i         (credit_i),
        .irq_o            (irq_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT did not finish", cycle_cnt);
            $display("Simulation failed");
            $finish;
        end
    end

    // memory, one read at a time, ack after a random wait
    always @(posedge clk) begin
        if (reset) begin
            m_ack_i <= 1'b0;
            m_dat_i <= '0;
            mem_wait = 0;
        end else if (m_ack_i) begin
            m_ack_i <= 1'b0;
        end else if (m_stb_o) begin
            if (mem_wait == 0) begin
                m_ack_i <= 1'b1;
                m_dat_i <= payload_t'(m_addr_o) ^ MEM_XOR;
                mem_wait = $urandom_range(3, 0);
            end else begin
                mem_wait = mem_wait - 1;
            end
        end
    end

    // link sink, credits go back after random delays unless held
    always @(posedge clk) begin
        if (reset) begin
            credit_i <= 1'b0;
            owed_credits = 0;
            cred_wait = 0;
        end else begin
            credit_i <= 1'b0;
            if (flit_wr_o) begin
                rx_q.push_back(flit_o);
                owed_credits = owed_credits + 1;
            end
            if (!hold_credits && owed_credits > 0) begin
                if (cred_wait == 0) begin
                    credit_i <= 1'b1;
                    owed_credits = owed_credits - 1;
                    cred_wait = $urandom_range(3, 0);
                end else begin
                    cred_wait = cred_wait - 1;
                end
            end
        end
    end

    task automatic check_reg(input string name, input payload_t got, input payload_t exp);
        check_cnt = check_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_cnt = check_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        check_cnt = check_cnt + 1;
        if (got !== exp) begin
            err_cnt = err_cnt + 1;
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic wait_ack();
        @(negedge clk);
        while (!s_ack_o) begin
            @(negedge clk);
        end
    endtask

    task automatic reg_write(input reg_addr_t addr, input payload_t data);
        @(posedge clk);
        s_addr_i <= addr;
        s_dat_i  <= data;
        s_stb_i  <= 1'b1;
        s_we_i   <= 1'b1;
        wait_ack();
        @(posedge clk);   // write lands on this edge
        s_stb_i <= 1'b0;
        s_we_i  <= 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output payload_t data);
        @(posedge clk);
        s_addr_i <= addr;
        s_stb_i  <= 1'b1;
        s_we_i   <= 1'b0;
        wait_ack();
        data = s_dat_o;
        @(posedge clk);
        s_stb_i <= 1'b0;
    endtask

    task automatic wait_idle();
        payload_t st;
        st = '1;
        while (st[BUSY_BIT]) begin
            reg_read(STATUS_ADDR, st);
        end
    endtask

    // all credits back and the flit record empty
    task automatic drain_link();
        @(negedge clk);
        while (owed_credits != 0) begin
            @(negedge clk);
        end
        rx_q.delete();
    endtask

    task automatic program_send(input mem_addr_t start, input pck_size_t size,
                                input e_addr_t dest, input class_t cls);
        reg_write(START_ADDR, payload_t'(start));
        reg_write(SIZE_ADDR, payload_t'(size));
        reg_write(DEST_ADDR, payload_t'(dest) | (payload_t'(cls) << 16));
        reg_write(SEND_ADDR, '0);
    endtask

    task automatic check_packet(input mem_addr_t start, input pck_size_t size,
                                input e_addr_t dest, input class_t cls);
        flit_t exp;
        flit_t got;
        int    n;
        n = int'(size) + 1;
        check_reg("flit count", payload_t'(rx_q.size()), payload_t'(n));
        if (rx_q.size() != n) begin
            rx_q.delete();
            return;
        end
        exp.hdr = 1'b1;
        exp.tail = 1'b0;
        exp.pay = '0;
        exp.pay[HDR_DEST_LSB +: 8]  = dest;
        exp.pay[HDR_SRC_LSB +: 8]   = OWN_ADDR;
        exp.pay[HDR_CLASS_LSB +: 2] = cls;
        got = rx_q.pop_front();
        check_flit("header flit", got, exp);
        for (int i = 0; i < int'(size); i++) begin
            exp.hdr  = 1'b0;
            exp.tail = (i == int'(size) - 1);   // tail on the last word only
            exp.pay  = payload_t'(start + mem_addr_t'(4 * i)) ^ MEM_XOR;
            got = rx_q.pop_front();
            check_flit("body flit", got, exp);
        end
    endtask

    task automatic report_test(input string name, input int errs0);
        $display("%s: %s, %0d errors", name, (err_cnt == errs0) ? "ok" : "FAILED",
                 err_cnt - errs0);
    endtask

    task automatic test_readback();
        int       errs0;
        payload_t rd;
        errs0 = err_cnt;
        reg_read(STATUS_ADDR, rd);
        check_reg("status after reset", rd, '0);
        reg_write(SIZE_ADDR, 32'hffff_f3c7);
        reg_read(SIZE_ADDR, rd);
        check_reg("size", rd, 32'h0000_03c7);
        reg_write(START_ADDR, 32'h89ab_cdef);
        reg_read(START_ADDR, rd);
        check_reg("start", rd, 32'h89ab_cdef);
        reg_write(DEST_ADDR, 32'hffff_ffa5);
        reg_read(DEST_ADDR, rd);
        check_reg("dest", rd, 32'h0003_00a5);
        report_test("register readback", errs0);
    endtask

    task automatic test_single_packet();
        int       errs0;
        payload_t rd;
        errs0 = err_cnt;
        drain_link();
        program_send(32'h0000_1000, 10'd5, 8'h3c, 2'd2);
        reg_read(STATUS_ADDR, rd);
        check_bit("busy after send", rd[BUSY_BIT], 1'b1);
        wait_idle();
        check_packet(32'h0000_1000, 10'd5, 8'h3c, 2'd2);
        report_test("single packet", errs0);
    endtask

    task automatic test_back_pressure();
        int       errs0;
        payload_t rd;
        errs0 = err_cnt;
        drain_link();
        hold_credits = 1'b1;
        program_send(32'h0000_2040, 10'd9, 8'h05, 2'd1);
        repeat (40) @(negedge clk);
        check_reg("flits with credits held", payload_t'(rx_q.size()), payload_t'(B));
        reg_read(STATUS_ADDR, rd);
        check_bit("busy while stalled", rd[BUSY_BIT], 1'b1);
        hold_credits = 1'b0;
        wait_idle();
        check_packet(32'h0000_2040, 10'd9, 8'h05, 2'd1);
        report_test("back-pressure", errs0);
    endtask

    task automatic test_errors();
        int       errs0;
        payload_t rd;
        errs0 = err_cnt;
        drain_link();
        reg_write(CTRL_ADDR, payload_t'(1) << CLR_ERR_BIT);
        reg_write(SIZE_ADDR, '0);
        reg_write(SEND_ADDR, '0);
        repeat (20) @(negedge clk);
        check_reg("flits for size 0", payload_t'(rx_q.size()), '0);
        reg_read(STATUS_ADDR, rd);
        check_bit("size error", rd[SIZE_ERR_BIT], 1'b1);
        check_bit("busy after size 0", rd[BUSY_BIT], 1'b0);
        program_send(32'h0000_3000, 10'd6, 8'h44, 2'd3);
        reg_write(SEND_ADDR, '0);   // second send while busy
        wait_idle();
        check_packet(32'h0000_3000, 10'd6, 8'h44, 2'd3);
        reg_read(STATUS_ADDR, rd);
        check_bit("illegal request", rd[ILLEGAL_REQ_BIT], 1'b1);
        check_bit("size error kept", rd[SIZE_ERR_BIT], 1'b1);
        reg_write(CTRL_ADDR, payload_t'(1) << CLR_ERR_BIT);
        reg_read(STATUS_ADDR, rd);
        check_bit("size error cleared", rd[SIZE_ERR_BIT], 1'b0);
        check_bit("illegal request cleared", rd[ILLEGAL_REQ_BIT], 1'b0);
        report_test("errors", errs0);
    endtask

    task automatic test_interrupt();
        int       errs0;
        payload_t rd;
        payload_t clr_isr;
        payload_t int_en;
        errs0   = err_cnt;
        clr_isr = payload_t'(1) << DONE_ISR_BIT;
        int_en  = payload_t'(1) << DONE_INT_EN_BIT;
        drain_link();
        reg_write(CTRL_ADDR, clr_isr);   // enable off
        program_send(32'h0000_4000, 10'd4, 8'h21, 2'd0);
        wait_idle();
        check_packet(32'h0000_4000, 10'd4, 8'h21, 2'd0);
        reg_read(STATUS_ADDR, rd);
        check_bit("isr with enable off", rd[DONE_ISR_BIT], 1'b1);
        @(negedge clk);
        check_bit("irq_o with enable off", irq_o, 1'b0);
        drain_link();
        reg_write(CTRL_ADDR, int_en | clr_isr);
        repeat (2) @(negedge clk);
        check_bit("irq_o after isr clear", irq_o, 1'b0);
        program_send(32'h0000_4100, 10'd4, 8'h22, 2'd1);
        @(negedge clk);
        while (!irq_o) begin
            @(negedge clk);
        end
        check_packet(32'h0000_4100, 10'd4, 8'h22, 2'd1);
        reg_read(STATUS_ADDR, rd);
        check_bit("isr with enable on", rd[DONE_ISR_BIT], 1'b1);
        check_bit("busy at irq", rd[BUSY_BIT], 1'b0);
        reg_write(CTRL_ADDR, int_en | clr_isr);
        repeat (2) @(negedge clk);
        check_bit("irq_o after clear", irq_o, 1'b0);
        reg_read(STATUS_ADDR, rd);
        check_bit("isr after clear", rd[DONE_ISR_BIT], 1'b0);
        report_test("interrupt", errs0);
    endtask

    task automatic test_random_packets();
        int        errs0;
        pck_size_t size;
        mem_addr_t start;
        e_addr_t   dest;
        class_t    cls;
        errs0 = err_cnt;
        drain_link();
        for (int p = 0; p < RAND_PCKS; p++) begin
            size  = pck_size_t'($urandom_range(16, 1));
            start = mem_addr_t'($urandom) & 32'h000f_fffc;   // word aligned
            dest  = e_addr_t'($urandom);
            cls   = class_t'($urandom);
            program_send(start, size, dest, cls);
            wait_idle();
            check_packet(start, size, dest, cls);
        end
        report_test("random packets", errs0);
    endtask

    initial begin
        void'($urandom(32'hb410));
        clk              = 1'b0;
        reset            = 1'b1;
        current_e_addr_i = OWN_ADDR;
        s_addr_i         = '0;
        s_dat_i          = '0;
        s_stb_i          = 1'b0;
        s_we_i           = 1'b0;
        m_dat_i          = '0;
        m_ack_i          = 1'b0;
        credit_i         = 1'b0;
        hold_credits     = 1'b0;
        owed_credits     = 0;
        cred_wait        = 0;
        mem_wait         = 0;
        check_cnt        = 0;
        err_cnt          = 0;
        cycle_cnt        = 0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        test_readback();
        test_single_packet();
        test_back_pressure();
        test_errors();
        test_interrupt();
        test_random_packets();

        $display("checks %0d, errors %0d, assertion failures %0d", check_cnt, err_cnt,
                 u_ni_master.u_chk.assert_fails);
        if (err_cnt == 0 && u_ni_master.u_chk.assert_fails == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/ni_master_chk.sv ====
// protocol assertions bound to the network interface master
// slave ack pulse, link credit limit, read address hold

`timescale 1ns/100ps
`default_nettype none

module ni_master_chk #(
    parameter int B = 4
) (
    input logic                  clk,
    input logic                  reset,
    input logic                  s_ack_o,
    input logic                  flit_wr_o,
    input logic                  credit_i,
    input logic                  m_stb_o,
    input logic                  m_ack_i,
    input ni_noc_pkg::mem_addr_t m_addr_o
);
    int out_cnt;            // flits on the link not yet credited
    int assert_fails = 0;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_cnt <= 0;
        end else begin
            out_cnt <= out_cnt + int'(flit_wr_o) - int'(credit_i);
        end
    end

    ack_single: assert property (@(posedge clk) disable iff (reset) s_ack_o |=> !s_ack_o)
        else begin
            $error("s_ack_o high for two cycles in a row");
            assert_fails = assert_fails + 1;
        end

    credit_limit: assert property (@(posedge clk) disable iff (reset)
        flit_wr_o |-> (out_cnt < B))
        else begin
            $error("flit written with no credit left");
            assert_fails = assert_fails + 1;
        end

    addr_hold: assert property (@(posedge clk) disable iff (reset)
        (m_stb_o && !m_ack_i) |=> (m_stb_o && $stable(m_addr_o)))
        else begin
            $error("read strobe or address changed before ack");
            assert_fails = assert_fails + 1;
        end

endmodule

bind ni_master ni_master_chk #(.B(B)) u_chk (
    .clk       (clk),
    .reset     (reset),
    .s_ack_o   (s_ack_o),
    .flit_wr_o (flit_wr_o),
    .credit_i  (credit_i),
    .m_stb_o   (m_stb_o),
    .m_ack_i   (m_ack_i),
    .m_addr_o  (m_addr_o)
);

`default_nettype wire

// ==== rtl/ni_master.sv ====
// DMA network interface master, top level
// register slave, send DMA engine and flit framer

`timescale 1ns/100ps
`default_nettype none

module ni_master #(
    parameter int B = 4   // link buffer depth in flits
) (
    input  logic                   clk,
    input  logic                   reset,
    input  ni_noc_pkg::e_addr_t    current_e_addr_i,
    input  ni_regs_pkg::reg_addr_t s_addr_i,
    input  ni_noc_pkg::payload_t   s_dat_i,
    input  logic                   s_stb_i,
    input  logic                   s_we_i,
    output ni_noc_pkg::payload_t   s_dat_o,
    output logic                   s_ack_o,
    output ni_noc_pkg::mem_addr_t  m_addr_o,
    output logic                   m_stb_o,
    input  ni_noc_pkg::payload_t   m_dat_i,
    input  logic                   m_ack_i,
    output ni_noc_pkg::flit_t      flit_o,
    output logic                   flit_wr_o,
    input  logic                   credit_i,
    output logic                   irq_o
);
    import ni_regs_pkg::*;

    send_desc_t send_desc;
    logic       send_start;
    logic       busy;
    logic       send_done;
    logic       hdr_wr;
    logic       body_wr;
    logic       last_word;
    logic       link_full;

    ni_reg_slave u_reg_slave (
        .clk          (clk),
        .reset        (reset),
        .s_addr_i     (s_addr_i),
        .s_dat_i      (s_dat_i),
        .s_stb_i      (s_stb_i),
        .s_we_i       (s_we_i),
        .s_dat_o      (s_dat_o),
        .s_ack_o      (s_ack_o),
        .busy_i       (busy),
        .send_done_i  (send_done),
        .send_desc_o  (send_desc),
        .send_start_o (send_start),
        .irq_o        (irq_o)
    );

    ni_send_dma u_send_dma (
        .clk          (clk),
        .reset        (reset),
        .send_desc_i  (send_desc),
        .send_start_i (send_start),
        .busy_o       (busy),
        .send_done_o  (send_done),
        .link_full_i  (link_full),
        .m_addr_o     (m_addr_o),
        .m_stb_o      (m_stb_o),
        .m_ack_i      (m_ack_i),
        .hdr_wr_o     (hdr_wr),
        .body_wr_o    (body_wr),
        .last_word_o  (last_word)
    );

    // memory data goes straight into the body flit
    ni_flit_framer #(
        .B (B)
    ) u_flit_framer (
        .clk              (clk),
        .reset            (reset),
        .current_e_addr_i (current_e_addr_i),
        .dest_i           (send_desc.dest),
        .class_i          (send_desc.cls),
        .dat_i            (m_dat_i),
        .hdr_wr_i         (hdr_wr),
        .body_wr_i        (body_wr),
        .last_word_i      (last_word),
        .credit_i         (credit_i),
        .flit_o           (flit_o),
        .flit_wr_o        (flit_wr_o),
        .link_full_o      (link_full)
    );

endmodule

`default_nettype wire

// ==== rtl/ni_flit_framer.sv ====
// flit framer for the output link
// header, body and tail flit assembly
// outstanding flit counter against the receiver buffer depth

`timescale 1ns/100ps
`default_nettype none

module ni_flit_framer #(
    parameter int B = 4   // receiver buffer depth in flits
) (
    input  logic                 clk,
    input  logic                 reset,
    input  ni_noc_pkg::e_addr_t  current_e_addr_i,
    input  ni_noc_pkg::e_addr_t  dest_i,
    input  ni_noc_pkg::class_t   class_i,
    input  ni_noc_pkg::payload_t dat_i,
    input  logic                 hdr_wr_i,
    input  logic                 body_wr_i,
    input  logic                 last_word_i,
    input  logic                 credit_i,
    output ni_noc_pkg::flit_t    flit_o,
    output logic                 flit_wr_o,
    output logic                 link_full_o
);
    import ni_noc_pkg::*;

    localparam int CNT_W = $clog2(B + 1);

    logic [CNT_W-1:0] out_cnt;   // flits not yet credited back
    payload_t         hdr_pay;

    always_comb begin
        hdr_pay = '0;
        hdr_pay[HDR_DEST_LSB +: $bits(e_addr_t)]  = dest_i;
        hdr_pay[HDR_SRC_LSB +: $bits(e_addr_t)]   = current_e_addr_i;
        hdr_pay[HDR_CLASS_LSB +: $bits(class_t)]  = class_i;
    end

    assign flit_o.hdr  = hdr_wr_i;
    assign flit_o.tail = body_wr_i & last_word_i;
    assign flit_o.pay  = hdr_wr_i ? hdr_pay : dat_i;
    assign flit_wr_o   = hdr_wr_i | body_wr_i;
    assign link_full_o = (out_cnt == CNT_W'(B));   // credits exhausted

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_cnt <= '0;
        end else if (flit_wr_o && !credit_i) begin
            out_cnt <= out_cnt + CNT_W'(1);
        end else if (!flit_wr_o && credit_i) begin
            out_cnt <= out_cnt - CNT_W'(1);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ni_send_dma.sv ====
// send DMA engine
// idle, header and body FSM with a single outstanding memory read
// address pointer and words-left counter

`timescale 1ns/100ps
`default_nettype none

module ni_send_dma (
    input  logic                    clk,
    input  logic                    reset,
    input  ni_regs_pkg::send_desc_t send_desc_i,
    input  logic                    send_start_i,
    output logic                    busy_o,
    output logic                    send_done_o,
    input  logic                    link_full_i,
    output ni_noc_pkg::mem_addr_t   m_addr_o,
    output logic                    m_stb_o,
    input  logic                    m_ack_i,
    output logic                    hdr_wr_o,
    output logic                    body_wr_o,
    output logic                    last_word_o
);
    import ni_noc_pkg::*;
    import ni_regs_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_HDR,
        S_BODY
    } state_t;

    state_t    state_q;
    state_t    state_d;
    mem_addr_t addr_q;       // next word to fetch
    pck_size_t words_left;
    logic      word_ack;

    assign busy_o   = (state_q != S_IDLE);
    assign hdr_wr_o = (state_q == S_HDR) & ~link_full_i;

    // no writes happen while a read waits, so credit only grows
    // and the strobe cannot drop before the ack
    assign m_stb_o     = (state_q == S_BODY) & ~link_full_i;
    assign m_addr_o    = addr_q;
    assign word_ack    = m_stb_o & m_ack_i;
    assign body_wr_o   = word_ack;   // flit leaves with the memory data
    assign last_word_o = (state_q == S_BODY) && (words_left == pck_size_t'(1));
    assign send_done_o = word_ack & last_word_o;

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (send_start_i) begin
                    state_d = S_HDR;
                end
            end
            S_HDR: begin
                if (hdr_wr_o) begin
                    state_d = S_BODY;
                end
            end
            S_BODY: begin
                if (send_done_o) begin
                    state_d = S_IDLE;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // datapath counters
    always_ff @(posedge clk) begin
        if (send_start_i && state_q == S_IDLE) begin
            addr_q     <= send_desc_i.start;
            words_left <= send_desc_i.size;
        end else if (word_ack) begin
            addr_q     <= addr_q + mem_addr_t'(4);   // one 32-bit word
            words_left <= words_left - pck_size_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== rtl/ni_reg_slave.sv ====
// register slave of the DMA network interface
// descriptor storage, start request qualification
// done interrupt and sticky error flags

`timescale 1ns/100ps
`default_nettype none

module ni_reg_slave (
    input  logic                    clk,
    input  logic                    reset,
    input  ni_regs_pkg::reg_addr_t  s_addr_i,
    input  ni_noc_pkg::payload_t    s_dat_i,
    input  logic                    s_stb_i,
    input  logic                    s_we_i,
    output ni_noc_pkg::payload_t    s_dat_o,
    output logic                    s_ack_o,
    input  logic                    busy_i,
    input  logic                    send_done_i,
    output ni_regs_pkg::send_desc_t send_desc_o,
    output logic                    send_start_o,
    output logic                    irq_o
);
    import ni_noc_pkg::*;
    import ni_regs_pkg::*;

    logic wr_en;
    logic send_req;
    logic size_ok;
    logic done_isr;
    logic done_int_en;
    err_t err;

    assign wr_en        = s_stb_i & s_we_i & s_ack_o;   // write lands on the ack cycle
    assign send_req     = wr_en & (s_addr_i == SEND_ADDR);
    assign size_ok      = (send_desc_o.size != '0);   // upper limit set by the field width
    assign send_start_o = send_req & ~busy_i & size_ok;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s_ack_o <= 1'b0;
        end else begin
            s_ack_o <= s_stb_i & ~s_ack_o;   // single cycle ack
        end
    end

    // descriptor is frozen while a send runs
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            send_desc_o <= '0;
        end else if (wr_en && !busy_i) begin
            case (s_addr_i)
                SIZE_ADDR:  send_desc_o.size  <= s_dat_i[$bits(pck_size_t)-1:0];
                START_ADDR: send_desc_o.start <= mem_addr_t'(s_dat_i);
                DEST_ADDR: begin
                    send_desc_o.dest <= s_dat_i[DEST_FIELD_LSB +: $bits(e_addr_t)];
                    send_desc_o.cls  <= s_dat_i[CLASS_FIELD_LSB +: $bits(class_t)];
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done_isr    <= 1'b0;
            done_int_en <= 1'b0;
            err         <= '0;
            irq_o       <= 1'b0;
        end else begin
            irq_o <= done_isr & done_int_en;
            if (wr_en && s_addr_i == CTRL_ADDR) begin
                done_int_en <= s_dat_i[DONE_INT_EN_BIT];
                if (s_dat_i[DONE_ISR_BIT]) begin
                    done_isr <= 1'b0;   // write one to clear
                end
                if (s_dat_i[CLR_ERR_BIT]) begin
                    err <= '0;
                end
            end
            if (send_req && busy_i) begin
                err.ill_req <= 1'b1;
            end
            if (send_req && !busy_i && !size_ok) begin
                err.size_err <= 1'b1;
            end
            // a new done beats a clear in the same cycle
            if (send_done_i) begin
                done_isr <= 1'b1;
            end
        end
    end

    always_comb begin
        s_dat_o = '0;   // unmapped reads as zero
        case (s_addr_i)
            STATUS_ADDR: begin
                s_dat_o[BUSY_BIT]        = busy_i;
                s_dat_o[DONE_ISR_BIT]    = done_isr;
                s_dat_o[DONE_INT_EN_BIT] = done_int_en;
                s_dat_o[SIZE_ERR_BIT]    = err.size_err;
                s_dat_o[ILLEGAL_REQ_BIT] = err.ill_req;
            end
            CTRL_ADDR: begin
                s_dat_o[DONE_ISR_BIT]    = done_isr;
                s_dat_o[DONE_INT_EN_BIT] = done_int_en;
            end
            SIZE_ADDR:  s_dat_o[$bits(pck_size_t)-1:0] = send_desc_o.size;
            START_ADDR: s_dat_o = payload_t'(send_desc_o.start);
            DEST_ADDR: begin
                s_dat_o[DEST_FIELD_LSB +: $bits(e_addr_t)] = send_desc_o.dest;
                s_dat_o[CLASS_FIELD_LSB +: $bits(class_t)] = send_desc_o.cls;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/ni_regs_pkg.sv ====
// software side definitions of the network interface
// register map, status and control bit positions
// send descriptor and sticky error flags

`default_nettype none

package ni_regs_pkg;

    typedef logic [3:0] reg_addr_t;

    localparam reg_addr_t STATUS_ADDR = 4'd0;   // read only
    localparam reg_addr_t CTRL_ADDR   = 4'd1;
    localparam reg_addr_t SIZE_ADDR   = 4'd3;
    localparam reg_addr_t START_ADDR  = 4'd4;
    localparam reg_addr_t DEST_ADDR   = 4'd5;
    localparam reg_addr_t SEND_ADDR   = 4'd6;   // any write starts a send

    // fields of the DEST register
    localparam int DEST_FIELD_LSB  = 0;
    localparam int CLASS_FIELD_LSB = 16;

    typedef logic [9:0] pck_size_t;   // packet size in words
    localparam pck_size_t MAX_PCK_WORDS = 10'd1023;

    localparam int BUSY_BIT        = 0;
    localparam int DONE_ISR_BIT    = 1;
    localparam int DONE_INT_EN_BIT = 2;
    localparam int SIZE_ERR_BIT    = 3;
    localparam int ILLEGAL_REQ_BIT = 4;
    localparam int CLR_ERR_BIT     = 3;   // CTRL write, clears both errors

    typedef struct packed {
        ni_noc_pkg::mem_addr_t start;
        pck_size_t             size;
        ni_noc_pkg::e_addr_t   dest;
        ni_noc_pkg::class_t    cls;
    } send_desc_t;

    typedef struct packed {
        logic ill_req;
        logic size_err;
    } err_t;

endpackage

`default_nettype wire

// ==== rtl/ni_noc_pkg.sv ====
// network side types for the DMA network interface
// flit layout, endpoint address, packet class and payload words
// header payload field positions

`default_nettype none

package ni_noc_pkg;

    localparam int FPAY = 32;   // flit payload width

    typedef logic [FPAY-1:0] payload_t;   // also one memory data word
    typedef logic [7:0]      e_addr_t;
    typedef logic [1:0]      class_t;
    typedef logic [31:0]     mem_addr_t;  // byte address on the read master

    // one link flit, a body flit has both flags clear
    typedef struct packed {
        logic     hdr;
        logic     tail;
        payload_t pay;
    } flit_t;

    // header payload fields, remaining bits zero
    localparam int HDR_DEST_LSB  = 0;
    localparam int HDR_SRC_LSB   = 8;
    localparam int HDR_CLASS_LSB = 16;

endpackage

`default_nettype wire
